// File: rtl/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_XLEN       64
`define RV_INST_W     32
`define RV_RESET_PC   64'h0000_0000_8000_0000

`define RV_OP_OP      7'b0110011
`define RV_OP_IMM     7'b0010011
`define RV_OP_LUI     7'b0110111
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_JAL     7'b1101111

`define RV_F3_ADD     3'b000
`define RV_F3_SLL     3'b001
`define RV_F3_SLT     3'b010
`define RV_F3_XOR     3'b100
`define RV_F3_SRL     3'b101
`define RV_F3_OR      3'b110
`define RV_F3_AND     3'b111
`define RV_F3_DW      3'b011
`define RV_F3_BEQ     3'b000
`define RV_F3_BNE     3'b001

`define RV_F7_BASE    7'b0000000
`define RV_F7_SUB     7'b0100000

`endif

// File: rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	// one 32-bit word, six ways to read its fields
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s;
		struct packed {
			logic       imm12;
			logic [5:0] imm10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4_1;
			logic       imm11;
			logic [6:0] opcode;
		} b;
		struct packed {
			logic [19:0] imm;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u;
		struct packed {
			logic       imm20;
			logic [9:0] imm10_1;
			logic       imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} inst_u;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		// lui result is the immediate itself
		ALU_PASS_B
	} alu_op_e;

endpackage

`default_nettype wire

// File: rtl/rv_pipe_pkg.sv
`default_nettype none

`include "rv_consts.svh"

package rv_pipe_pkg;

	typedef struct packed {
		logic                    valid;
		logic [`RV_XLEN-1:0]     pc;
		logic [`RV_INST_W-1:0]   inst;
		logic [4:0]              rs1_addr;
		logic [4:0]              rs2_addr;
		logic [`RV_XLEN-1:0]     rs1_data;
		logic [`RV_XLEN-1:0]     rs2_data;
		logic [`RV_XLEN-1:0]     imm;
		rv_isa_pkg::alu_op_e     alu_op;
		logic                    imm_sel;
		logic                    is_load;
		logic                    is_store;
		logic                    is_branch;
		logic                    is_jal;
		logic                    is_bne;
		logic                    rd_wena;
		logic [4:0]              rd_addr;
	} id_ex_t;

	typedef struct packed {
		logic                    valid;
		logic [`RV_XLEN-1:0]     pc;
		logic [`RV_INST_W-1:0]   inst;
		logic [`RV_XLEN-1:0]     alu_result;
		logic [`RV_XLEN-1:0]     store_data;
		logic                    is_load;
		logic                    is_store;
		logic                    rd_wena;
		logic [4:0]              rd_addr;
	} ex_me_t;

	typedef struct packed {
		logic                    valid;
		logic [`RV_XLEN-1:0]     pc;
		logic [`RV_INST_W-1:0]   inst;
		logic [`RV_XLEN-1:0]     rd_data;
		logic                    rd_wena;
		logic [4:0]              rd_addr;
	} me_wb_t;

	typedef enum logic [1:0] {
		FWD_RF = 2'd0,
		FWD_ME = 2'd1,
		FWD_WB = 2'd2
	} fwd_src_e;

	typedef struct packed {
		logic                    valid;
		logic [`RV_XLEN-1:0]     pc;
		logic [`RV_INST_W-1:0]   inst;
		logic                    rd_wena;
		logic [4:0]              rd_addr;
		logic [`RV_XLEN-1:0]     rd_data;
	} retire_t;

	typedef struct packed {
		logic                    taken;
		logic [`RV_XLEN-1:0]     target;
	} redirect_t;

endpackage

`default_nettype wire

// File: rtl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module fetch_unit (
	input  wire                     clk,
	input  wire                     rst_n_i,
	input  wire                     if_ready_i,
	input  wire [`RV_INST_W-1:0]    if_data_read_i,
	input  wire                     hold_i,
	input  wire                     stall_i,
	input  rv_pipe_pkg::redirect_t  redirect_i,
	output logic                    if_valid_o,
	output logic [`RV_XLEN-1:0]     if_addr_o,
	output logic                    ifid_valid_o,
	output logic [`RV_XLEN-1:0]     ifid_pc_o,
	output logic [`RV_INST_W-1:0]   ifid_inst_o
);

	logic [`RV_XLEN-1:0] pc_q;
	logic [`RV_XLEN-1:0] pend_pc_q;
	logic                run_q;
	logic                pend_q;
	logic                fire;

	// no new request while decode is frozen
	assign if_valid_o = run_q & ~stall_i & ~hold_i;
	assign if_addr_o  = pc_q;
	assign fire       = if_valid_o & if_ready_i;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			run_q  <= 1'b0;
			pend_q <= 1'b0;
			pc_q   <= `RV_RESET_PC;
		end else begin
			run_q <= 1'b1;
			if (redirect_i.taken && if_valid_o && !if_ready_i) begin
				// request in flight, address must stay put
				pend_q <= 1'b1;
			end else if (redirect_i.taken) begin
				pend_q <= 1'b0;
				pc_q   <= redirect_i.target;
			end else if (fire) begin
				pend_q <= 1'b0;
				pc_q   <= pend_q ? pend_pc_q : pc_q + `RV_XLEN'd4;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (redirect_i.taken) begin
			pend_pc_q <= redirect_i.target;
		end
	end

	// if/id register
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ifid_valid_o <= 1'b0;
		end else if (redirect_i.taken) begin
			ifid_valid_o <= 1'b0;
		end else if (fire) begin
			// stale word from before a redirect is dropped
			ifid_valid_o <= ~pend_q;
		end else if (!stall_i && !hold_i) begin
			ifid_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			ifid_pc_o   <= pc_q;
			ifid_inst_o <= if_data_read_i;
		end
	end

endmodule

`default_nettype wire

// File: rtl/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module id_stage (
	input  wire                    clk,
	input  wire                    rst_n_i,
	input  wire                    ifid_valid_i,
	input  wire [`RV_XLEN-1:0]     ifid_pc_i,
	input  wire [`RV_INST_W-1:0]   ifid_inst_i,
	input  wire [`RV_XLEN-1:0]     rs1_data_i,
	input  wire [`RV_XLEN-1:0]     rs2_data_i,
	input  wire                    hold_i,
	input  wire                    bubble_i,
	input  wire                    flush_i,
	output logic [4:0]             rs1_addr_o,
	output logic [4:0]             rs2_addr_o,
	output logic                   rs1_used_o,
	output logic                   rs2_used_o,
	output rv_pipe_pkg::id_ex_t    idex_o
);

	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	inst_u   iw;
	id_ex_t  idex_d;
	alu_op_e f3_op;
	logic    f3_ok;
	logic    ok;
	logic    use_rs1;
	logic    use_rs2;

	assign iw         = ifid_inst_i;
	assign rs1_addr_o = iw.r.rs1;
	assign rs2_addr_o = iw.r.rs2;
	assign rs1_used_o = ifid_valid_i & use_rs1;
	assign rs2_used_o = ifid_valid_i & use_rs2;

	// funct3 to alu op, shared by op and op-imm
	always_comb begin
		f3_ok = 1'b1;
		case (iw.r.funct3)
			`RV_F3_ADD: f3_op = ALU_ADD;
			`RV_F3_SLL: f3_op = ALU_SLL;
			`RV_F3_SLT: f3_op = ALU_SLT;
			`RV_F3_XOR: f3_op = ALU_XOR;
			`RV_F3_SRL: f3_op = ALU_SRL;
			`RV_F3_OR:  f3_op = ALU_OR;
			`RV_F3_AND: f3_op = ALU_AND;
			default: begin
				f3_op = ALU_ADD;
				f3_ok = 1'b0;
			end
		endcase
	end

	always_comb begin
		idex_d          = '0;
		idex_d.valid    = ifid_valid_i;
		idex_d.pc       = ifid_pc_i;
		idex_d.inst     = ifid_inst_i;
		idex_d.rs1_addr = iw.r.rs1;
		idex_d.rs2_addr = iw.r.rs2;
		idex_d.rs1_data = rs1_data_i;
		idex_d.rs2_data = rs2_data_i;
		idex_d.alu_op   = ALU_ADD;
		ok      = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (iw.r.opcode)
			`RV_OP_OP: begin
				ok = f3_ok & ((iw.r.funct7 == `RV_F7_BASE) |
					((iw.r.funct7 == `RV_F7_SUB) & (iw.r.funct3 == `RV_F3_ADD)));
				idex_d.alu_op = (iw.r.funct7 == `RV_F7_SUB) ? ALU_SUB : f3_op;
				use_rs1 = ok;
				use_rs2 = ok;
			end
			`RV_OP_IMM: begin
				// srai and friends carry a nonzero funct6
				ok = f3_ok & (((iw.r.funct3 != `RV_F3_SLL) & (iw.r.funct3 != `RV_F3_SRL)) |
					(iw.i.imm[11:6] == 6'b0));
				idex_d.alu_op  = f3_op;
				idex_d.imm     = {{(`RV_XLEN-12){iw.i.imm[11]}}, iw.i.imm};
				idex_d.imm_sel = 1'b1;
				use_rs1 = ok;
			end
			`RV_OP_LUI: begin
				ok = 1'b1;
				idex_d.alu_op  = ALU_PASS_B;
				idex_d.imm     = {{(`RV_XLEN-32){iw.u.imm[19]}}, iw.u.imm, 12'b0};
				idex_d.imm_sel = 1'b1;
			end
			`RV_OP_LOAD: begin
				ok = (iw.i.funct3 == `RV_F3_DW);
				idex_d.is_load = ok;
				idex_d.imm     = {{(`RV_XLEN-12){iw.i.imm[11]}}, iw.i.imm};
				idex_d.imm_sel = 1'b1;
				use_rs1 = ok;
			end
			`RV_OP_STORE: begin
				idex_d.is_store = (iw.s.funct3 == `RV_F3_DW);
				idex_d.imm      = {{(`RV_XLEN-12){iw.s.imm_hi[6]}}, iw.s.imm_hi, iw.s.imm_lo};
				idex_d.imm_sel  = 1'b1;
				use_rs1 = idex_d.is_store;
				use_rs2 = idex_d.is_store;
			end
			`RV_OP_BRANCH: begin
				idex_d.is_branch = (iw.b.funct3 == `RV_F3_BEQ) | (iw.b.funct3 == `RV_F3_BNE);
				idex_d.is_bne    = (iw.b.funct3 == `RV_F3_BNE);
				idex_d.imm       = {{(`RV_XLEN-12){iw.b.imm12}}, iw.b.imm11,
					iw.b.imm10_5, iw.b.imm4_1, 1'b0};
				use_rs1 = idex_d.is_branch;
				use_rs2 = idex_d.is_branch;
			end
			`RV_OP_JAL: begin
				ok = 1'b1;
				idex_d.is_jal = 1'b1;
				idex_d.imm    = {{(`RV_XLEN-20){iw.j.imm20}}, iw.j.imm19_12, iw.j.imm11,
					iw.j.imm10_1, 1'b0};
			end
			default: ok = 1'b0;
		endcase
		// anything else passes through as a no-op
		idex_d.rd_wena = ok & (iw.r.rd != 5'd0);
		idex_d.rd_addr = iw.r.rd;
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			idex_o <= '0;
		end else if (!hold_i) begin
			if (bubble_i || flush_i) begin
				idex_o <= '0;
			end else begin
				idex_o <= idex_d;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module regfile (
	input  wire                  clk,
	input  wire                  rst_n_i,
	input  wire [4:0]            rs1_addr_i,
	input  wire [4:0]            rs2_addr_i,
	input  rv_pipe_pkg::me_wb_t  wb_i,
	output logic [`RV_XLEN-1:0]  rs1_data_o,
	output logic [`RV_XLEN-1:0]  rs2_data_o
);

	logic [`RV_XLEN-1:0] regs_q [1:31];
	logic                wr_en;

	assign wr_en = wb_i.valid & wb_i.rd_wena & (wb_i.rd_addr != 5'd0);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int k = 1; k < 32; k++) begin
				regs_q[k] <= '0;
			end
		end else if (wr_en) begin
			regs_q[wb_i.rd_addr] <= wb_i.rd_data;
		end
	end

	// write-first, so decode sees this cycle's write-back
	always_comb begin
		if (rs1_addr_i == 5'd0) begin
			rs1_data_o = '0;
		end else if (wr_en && wb_i.rd_addr == rs1_addr_i) begin
			rs1_data_o = wb_i.rd_data;
		end else begin
			rs1_data_o = regs_q[rs1_addr_i];
		end
	end

	always_comb begin
		if (rs2_addr_i == 5'd0) begin
			rs2_data_o = '0;
		end else if (wr_en && wb_i.rd_addr == rs2_addr_i) begin
			rs2_data_o = wb_i.rd_data;
		end else begin
			rs2_data_o = regs_q[rs2_addr_i];
		end
	end

endmodule

`default_nettype wire

// File: rtl/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
	input  rv_pipe_pkg::id_ex_t  idex_i,
	input  wire [4:0]            rs1_addr_i,
	input  wire [4:0]            rs2_addr_i,
	input  wire                  rs1_used_i,
	input  wire                  rs2_used_i,
	input  wire                  mem_wait_i,
	output logic                 stall_o,
	output logic                 bubble_o,
	output logic                 hold_o
);

	logic ld_in_ex;
	logic rs1_hit;
	logic rs2_hit;

	// load result only exists once it leaves the memory stage
	assign ld_in_ex = idex_i.valid & idex_i.is_load & idex_i.rd_wena;
	assign rs1_hit  = rs1_used_i & (rs1_addr_i == idex_i.rd_addr);
	assign rs2_hit  = rs2_used_i & (rs2_addr_i == idex_i.rd_addr);

	assign stall_o  = ld_in_ex & (rs1_hit | rs2_hit);

	// id/ex only takes the bubble when it is free to move
	assign bubble_o = stall_o & ~mem_wait_i;

	// data port wait freezes every stage register
	assign hold_o   = mem_wait_i;

endmodule

`default_nettype wire

// File: rtl/exe_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module exe_stage (
	input  wire                     clk,
	input  wire                     rst_n_i,
	input  rv_pipe_pkg::id_ex_t     idex_i,
	input  rv_pipe_pkg::ex_me_t     me_fwd_i,
	input  rv_pipe_pkg::me_wb_t     wb_fwd_i,
	input  wire                     hold_i,
	output rv_pipe_pkg::redirect_t  redirect_o,
	output rv_pipe_pkg::ex_me_t     exme_o
);

	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	fwd_src_e            rs1_src;
	fwd_src_e            rs2_src;
	logic [`RV_XLEN-1:0] rs1_val;
	logic [`RV_XLEN-1:0] rs2_val;
	logic [`RV_XLEN-1:0] op_b;
	logic [`RV_XLEN-1:0] alu_out;
	logic                eq;
	ex_me_t              exme_d;

	// nearer stage wins, a load in me has no data yet
	function automatic fwd_src_e pick_src(input logic [4:0] rs, input ex_me_t me,
		input me_wb_t wb);
		fwd_src_e src;
		src = FWD_RF;
		if (me.valid && me.rd_wena && !me.is_load && me.rd_addr == rs) begin
			src = FWD_ME;
		end else if (wb.valid && wb.rd_wena && wb.rd_addr == rs) begin
			src = FWD_WB;
		end
		return src;
	endfunction

	function automatic logic [`RV_XLEN-1:0] sel_data(input fwd_src_e src,
		input logic [`RV_XLEN-1:0] rf, input ex_me_t me, input me_wb_t wb);
		logic [`RV_XLEN-1:0] d;
		case (src)
			FWD_ME:  d = me.alu_result;
			FWD_WB:  d = wb.rd_data;
			default: d = rf;
		endcase
		return d;
	endfunction

	always_comb begin
		rs1_src = pick_src(idex_i.rs1_addr, me_fwd_i, wb_fwd_i);
		rs2_src = pick_src(idex_i.rs2_addr, me_fwd_i, wb_fwd_i);
		rs1_val = sel_data(rs1_src, idex_i.rs1_data, me_fwd_i, wb_fwd_i);
		rs2_val = sel_data(rs2_src, idex_i.rs2_data, me_fwd_i, wb_fwd_i);
	end

	assign op_b = idex_i.imm_sel ? idex_i.imm : rs2_val;

	always_comb begin
		case (idex_i.alu_op)
			ALU_ADD:    alu_out = rs1_val + op_b;
			ALU_SUB:    alu_out = rs1_val - op_b;
			ALU_AND:    alu_out = rs1_val & op_b;
			ALU_OR:     alu_out = rs1_val | op_b;
			ALU_XOR:    alu_out = rs1_val ^ op_b;
			ALU_SLT:    alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
			ALU_SLL:    alu_out = rs1_val << op_b[5:0];
			ALU_SRL:    alu_out = rs1_val >> op_b[5:0];
			ALU_PASS_B: alu_out = op_b;
			default:    alu_out = '0;
		endcase
	end

	// beq/bne share one comparator
	assign eq = (rs1_val == rs2_val);
	assign redirect_o.taken  = idex_i.valid &
		(idex_i.is_jal | (idex_i.is_branch & (eq ^ idex_i.is_bne)));
	assign redirect_o.target = idex_i.pc + idex_i.imm;

	always_comb begin
		exme_d.valid      = idex_i.valid;
		exme_d.pc         = idex_i.pc;
		exme_d.inst       = idex_i.inst;
		// jal links the return address
		exme_d.alu_result = idex_i.is_jal ? idex_i.pc + `RV_XLEN'd4 : alu_out;
		exme_d.store_data = rs2_val;
		exme_d.is_load    = idex_i.is_load;
		exme_d.is_store   = idex_i.is_store;
		exme_d.rd_wena    = idex_i.rd_wena;
		exme_d.rd_addr    = idex_i.rd_addr;
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			exme_o <= '0;
		end else if (!hold_i) begin
			exme_o <= exme_d;
		end
	end

endmodule

`default_nettype wire

// File: rtl/me_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module me_stage (
	input  wire                   clk,
	input  wire                   rst_n_i,
	input  rv_pipe_pkg::ex_me_t   exme_i,
	input  wire                   mem_ready_i,
	input  wire [`RV_XLEN-1:0]    mem_data_read_i,
	output logic                  mem_valid_o,
	output logic                  mem_write_o,
	output logic [`RV_XLEN-1:0]   mem_addr_o,
	output logic [`RV_XLEN-1:0]   mem_data_write_o,
	output logic                  mem_wait_o,
	output rv_pipe_pkg::me_wb_t   mewb_o,
	output rv_pipe_pkg::retire_t  retire_o
);

	import rv_pipe_pkg::*;

	me_wb_t mewb_d;

	assign mem_valid_o      = exme_i.valid & (exme_i.is_load | exme_i.is_store);
	assign mem_write_o      = exme_i.is_store;
	assign mem_addr_o       = exme_i.alu_result;
	assign mem_data_write_o = exme_i.store_data;
	assign mem_wait_o       = mem_valid_o & ~mem_ready_i;

	always_comb begin
		mewb_d.valid   = exme_i.valid;
		mewb_d.pc      = exme_i.pc;
		mewb_d.inst    = exme_i.inst;
		// read data is only good in the ready cycle
		mewb_d.rd_data = exme_i.is_load ? mem_data_read_i : exme_i.alu_result;
		mewb_d.rd_wena = exme_i.rd_wena;
		mewb_d.rd_addr = exme_i.rd_addr;
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mewb_o <= '0;
		end else if (!mem_wait_o) begin
			mewb_o <= mewb_d;
		end
	end

	// held entry retires once, when the wait ends
	always_comb begin
		retire_o.valid   = mewb_o.valid & ~mem_wait_o;
		retire_o.pc      = mewb_o.pc;
		retire_o.inst    = mewb_o.inst;
		retire_o.rd_wena = mewb_o.rd_wena;
		retire_o.rd_addr = mewb_o.rd_addr;
		retire_o.rd_data = mewb_o.rd_data;
	end

endmodule

`default_nettype wire

// File: rtl/rvcpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rvcpu (
	input  wire                    clk,
	input  wire                    rst_n_i,
	input  wire                    if_ready_i,
	input  wire [`RV_INST_W-1:0]   if_data_read_i,
	output logic                   if_valid_o,
	output logic [`RV_XLEN-1:0]    if_addr_o,
	input  wire                    mem_ready_i,
	input  wire [`RV_XLEN-1:0]     mem_data_read_i,
	output logic                   mem_valid_o,
	output logic                   mem_write_o,
	output logic [`RV_XLEN-1:0]    mem_addr_o,
	output logic [`RV_XLEN-1:0]    mem_data_write_o,
	output rv_pipe_pkg::retire_t   retire_o
);

	import rv_pipe_pkg::*;

	logic                  ifid_valid;
	logic [`RV_XLEN-1:0]   ifid_pc;
	logic [`RV_INST_W-1:0] ifid_inst;
	logic [4:0]            rs1_addr;
	logic [4:0]            rs2_addr;
	logic                  rs1_used;
	logic                  rs2_used;
	logic [`RV_XLEN-1:0]   rs1_data;
	logic [`RV_XLEN-1:0]   rs2_data;
	logic                  stall;
	logic                  bubble;
	logic                  hold;
	logic                  mem_wait;
	id_ex_t                idex;
	ex_me_t                exme;
	me_wb_t                mewb;
	redirect_t             redirect;

	fetch_unit fetch_unit_i (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.if_ready_i     (if_ready_i),
		.if_data_read_i (if_data_read_i),
		.hold_i         (hold),
		.stall_i        (stall),
		.redirect_i     (redirect),
		.if_valid_o     (if_valid_o),
		.if_addr_o      (if_addr_o),
		.ifid_valid_o   (ifid_valid),
		.ifid_pc_o      (ifid_pc),
		.ifid_inst_o    (ifid_inst)
	);

	id_stage id_stage_i (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.ifid_valid_i (ifid_valid),
		.ifid_pc_i    (ifid_pc),
		.ifid_inst_i  (ifid_inst),
		.rs1_data_i   (rs1_data),
		.rs2_data_i   (rs2_data),
		.hold_i       (hold),
		.bubble_i     (bubble),
		.flush_i      (redirect.taken),
		.rs1_addr_o   (rs1_addr),
		.rs2_addr_o   (rs2_addr),
		.rs1_used_o   (rs1_used),
		.rs2_used_o   (rs2_used),
		.idex_o       (idex)
	);

	regfile regfile_i (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.wb_i       (mewb),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data)
	);

	hazard_unit hazard_unit_i (
		.idex_i     (idex),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.rs1_used_i (rs1_used),
		.rs2_used_i (rs2_used),
		.mem_wait_i (mem_wait),
		.stall_o    (stall),
		.bubble_o   (bubble),
		.hold_o     (hold)
	);

	// me forwarding reads the ex/me register directly
	exe_stage exe_stage_i (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.idex_i     (idex),
		.me_fwd_i   (exme),
		.wb_fwd_i   (mewb),
		.hold_i     (hold),
		.redirect_o (redirect),
		.exme_o     (exme)
	);

	me_stage me_stage_i (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.exme_i           (exme),
		.mem_ready_i      (mem_ready_i),
		.mem_data_read_i  (mem_data_read_i),
		.mem_valid_o      (mem_valid_o),
		.mem_write_o      (mem_write_o),
		.mem_addr_o       (mem_addr_o),
		.mem_data_write_o (mem_data_write_o),
		.mem_wait_o       (mem_wait),
		.mewb_o           (mewb),
		.retire_o         (retire_o)
	);

endmodule

`default_nettype wire

// File: bench/rvcpu_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module rvcpu_chk (
	input  wire                   clk,
	input  wire                   rst_n_i,
	input  wire                   if_valid_o,
	input  wire                   if_ready_i,
	input  wire [`RV_XLEN-1:0]    if_addr_o,
	input  wire                   mem_valid_o,
	input  wire                   mem_ready_i,
	input  wire                   mem_write_o,
	input  wire [`RV_XLEN-1:0]    mem_addr_o,
	input  wire [`RV_XLEN-1:0]    mem_data_write_o,
	input  rv_pipe_pkg::retire_t  retire_o
);

	import rv_pipe_pkg::*;

	int err_cnt = 0;

	// nothing leaves the core during reset
	quiet_in_reset: assert property (@(posedge clk)
		!rst_n_i |-> (!if_valid_o && !mem_valid_o && !retire_o.valid))
		else begin
			$error("port active while reset is low");
			err_cnt++;
		end

	first_fetch_addr: assert property (@(posedge clk)
		$rose(rst_n_i) |-> (if_addr_o == `RV_RESET_PC))
		else begin
			$error("first fetch address is not the reset PC");
			err_cnt++;
		end

	// valid may drop under a hold, but a kept request keeps its address
	fetch_addr_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
		(if_valid_o && !if_ready_i) |=> (!if_valid_o || $stable(if_addr_o)))
		else begin
			$error("fetch address moved while waiting for ready");
			err_cnt++;
		end

	data_req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
		(mem_valid_o && !mem_ready_i) |=> (mem_valid_o && $stable(mem_addr_o) &&
			$stable(mem_write_o) && $stable(mem_data_write_o)))
		else begin
			$error("data request changed while waiting for ready");
			err_cnt++;
		end

	no_retire_in_wait: assert property (@(posedge clk) disable iff (!rst_n_i)
		(mem_valid_o && !mem_ready_i) |-> !retire_o.valid)
		else begin
			$error("instruction retired during a data-port wait");
			err_cnt++;
		end

endmodule

bind rvcpu rvcpu_chk rvcpu_chk_i (.*);

`default_nettype wire

// File: bench/tb_rvcpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_consts.svh"

module tb_rvcpu;

	import rv_isa_pkg::*;
	import rv_pipe_pkg::*;

	localparam int CYCLE_LIMIT = 3000;
	localparam logic [63:0] FILL = 64'hc3a5_0f1e_9b7d_2468;

	logic                  clk;
	logic                  rst_n_i;
	logic                  if_ready_i;
	logic [`RV_INST_W-1:0] if_data_read_i;
	logic                  if_valid_o;
	logic [`RV_XLEN-1:0]   if_addr_o;
	logic                  mem_ready_i;
	logic [`RV_XLEN-1:0]   mem_data_read_i;
	logic                  mem_valid_o;
	logic                  mem_write_o;
	logic [`RV_XLEN-1:0]   mem_addr_o;
	logic [`RV_XLEN-1:0]   mem_data_write_o;
	retire_t               retire_o;

	logic [31:0] imem [0:63];
	int          n_inst;
	logic [63:0] dmem [logic [63:0]];
	logic [63:0] ref_mem [logic [63:0]];
	logic [63:0] ref_regs [0:31];
	logic [63:0] exp_pc;
	logic [64:0] xfer_q [$];
	logic [63:0] xdata_q [$];
	int          cycles;
	int          mism_cnt;
	int          timeout_cnt;
	logic        done;

	rvcpu rvcpu_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		inst_u w;
		w.r = '{f7, rs2, rs1, f3, rd, `RV_OP_OP};
		return w;
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		inst_u w;
		w.i = '{imm, rs1, f3, rd, op};
		return w;
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		inst_u w;
		w.s = '{imm[11:5], rs2, rs1, `RV_F3_DW, imm[4:0], `RV_OP_STORE};
		return w;
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		inst_u w;
		w.b = '{off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
		return w;
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
		inst_u w;
		w.j = '{off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
		return w;
	endfunction

	task automatic emit(input logic [31:0] w);
		imem[n_inst] = w;
		n_inst++;
	endtask

	task automatic load_program();
		n_inst = 0;
		emit(enc_i(12'd5, 5'd0, `RV_F3_ADD, 5'd1, `RV_OP_IMM));
		emit(enc_i(12'hffd, 5'd0, `RV_F3_ADD, 5'd2, `RV_OP_IMM));
		// back-to-back dependent alu chain
		emit(enc_r(`RV_F7_BASE, 5'd2, 5'd1, `RV_F3_ADD, 5'd3));
		emit(enc_r(`RV_F7_SUB, 5'd1, 5'd3, `RV_F3_ADD, 5'd4));
		emit(enc_r(`RV_F7_BASE, 5'd2, 5'd4, `RV_F3_AND, 5'd5));
		emit(enc_r(`RV_F7_BASE, 5'd1, 5'd5, `RV_F3_OR, 5'd6));
		emit(enc_r(`RV_F7_BASE, 5'd3, 5'd6, `RV_F3_XOR, 5'd7));
		emit(enc_r(`RV_F7_BASE, 5'd1, 5'd2, `RV_F3_SLT, 5'd8));
		emit(enc_r(`RV_F7_BASE, 5'd8, 5'd1, `RV_F3_SLL, 5'd9));
		emit(enc_r(`RV_F7_BASE, 5'd8, 5'd9, `RV_F3_SRL, 5'd10));
		emit(enc_i(12'h055, 5'd7, `RV_F3_XOR, 5'd11, `RV_OP_IMM));
		emit({20'h12345, 5'd12, `RV_OP_LUI});
		emit(enc_i(12'h100, 5'd0, `RV_F3_ADD, 5'd13, `RV_OP_IMM));
		// store then load, then a load-use pair
		emit(enc_s(12'd8, 5'd12, 5'd13));
		emit(enc_i(12'd8, 5'd13, `RV_F3_DW, 5'd14, `RV_OP_LOAD));
		emit(enc_r(`RV_F7_BASE, 5'd1, 5'd14, `RV_F3_ADD, 5'd15));
		emit(enc_s(12'd16, 5'd3, 5'd13));
		emit(enc_i(12'd16, 5'd13, `RV_F3_DW, 5'd16, `RV_OP_LOAD));
		emit(enc_b(13'd8, 5'd3, 5'd16, `RV_F3_BEQ));
		emit(enc_i(12'd99, 5'd0, `RV_F3_ADD, 5'd17, `RV_OP_IMM));
		emit(enc_b(13'd8, 5'd3, 5'd16, `RV_F3_BNE));
		emit(enc_i(12'd3, 5'd0, `RV_F3_ADD, 5'd18, `RV_OP_IMM));
		emit(enc_i(12'd0, 5'd0, `RV_F3_ADD, 5'd19, `RV_OP_IMM));
		// three-pass backward loop
		emit(enc_r(`RV_F7_BASE, 5'd1, 5'd19, `RV_F3_ADD, 5'd19));
		emit(enc_i(12'hfff, 5'd18, `RV_F3_ADD, 5'd18, `RV_OP_IMM));
		emit(enc_b(13'h1ff8, 5'd0, 5'd18, `RV_F3_BNE));
		emit(enc_b(13'd8, 5'd1, 5'd18, `RV_F3_BEQ));
		emit(enc_i(12'h0f0, 5'd19, `RV_F3_OR, 5'd20, `RV_OP_IMM));
		emit(enc_i(12'd2, 5'd20, `RV_F3_SRL, 5'd21, `RV_OP_IMM));
		emit(enc_i(12'd4, 5'd12, `RV_F3_SLL, 5'd22, `RV_OP_IMM));
		emit(enc_j(21'd8, 5'd23));
		emit(enc_i(12'd7, 5'd0, `RV_F3_ADD, 5'd24, `RV_OP_IMM));
		emit(enc_i(12'h0ff, 5'd23, `RV_F3_AND, 5'd24, `RV_OP_IMM));
		emit(enc_i(12'd8, 5'd13, `RV_F3_DW, 5'd25, `RV_OP_LOAD));
		emit(enc_b(13'd8, 5'd12, 5'd25, `RV_F3_BEQ));
		emit(enc_i(12'd1, 5'd0, `RV_F3_ADD, 5'd26, `RV_OP_IMM));
		emit(enc_r(`RV_F7_SUB, 5'd14, 5'd25, `RV_F3_ADD, 5'd26));
		emit(enc_j(21'd0, 5'd0));
	endtask

	function automatic logic [31:0] fetch_word(input logic [63:0] addr);
		logic [63:0] idx;
		idx = (addr - `RV_RESET_PC) >> 2;
		if (addr >= `RV_RESET_PC && idx < n_inst) begin
			return imem[idx];
		end
		return 32'h0000_0013;
	endfunction

	// untouched doublewords read a pattern of their whole address
	function automatic logic [63:0] read_data(input logic [63:0] addr, input logic ref_copy);
		if (ref_copy) begin
			return ref_mem.exists(addr) ? ref_mem[addr] : (addr ^ FILL);
		end
		return dmem.exists(addr) ? dmem[addr] : (addr ^ FILL);
	endfunction

	always @(negedge clk) begin
		if_ready_i      <= ($urandom % 4) != 0;
		mem_ready_i     <= ($urandom % 3) != 0;
		if_data_read_i  <= fetch_word(if_addr_o);
		mem_data_read_i <= read_data(mem_addr_o, 1'b0);
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
	end

	// data memory and the ISA mirror
	always @(posedge clk) begin
		inst_u       d;
		logic [63:0] pc;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] imm_i;
		logic [63:0] res;
		logic [63:0] nxt;
		logic [64:0] rec;
		logic        wr;
		if (rst_n_i && mem_valid_o && mem_ready_i) begin
			xfer_q.push_back({mem_write_o, mem_addr_o});
			xdata_q.push_back(mem_data_write_o);
			if (mem_write_o) begin
				dmem[mem_addr_o] = mem_data_write_o;
			end
		end
		if (rst_n_i && retire_o.valid && !done) begin
			pc    = exp_pc;
			d     = fetch_word(pc);
			a     = ref_regs[d.r.rs1];
			b     = ref_regs[d.r.rs2];
			imm_i = {{52{d.i.imm[11]}}, d.i.imm};
			res   = '0;
			wr    = 1'b0;
			nxt   = pc + 64'd4;
			assert (retire_o.pc == pc) else begin
				$display("Mismatch at %0t: retired pc %h, expected %h", $time,
					retire_o.pc, pc);
				mism_cnt++;
			end
			assert (retire_o.inst == d) else begin
				$display("Mismatch at %0t: retired inst %h, expected %h", $time,
					retire_o.inst, d);
				mism_cnt++;
			end
			if (d.r.opcode == `RV_OP_OP || d.r.opcode == `RV_OP_IMM) begin
				if (d.r.opcode == `RV_OP_IMM) begin
					b = imm_i;
				end
				wr = 1'b1;
				case (d.r.funct3)
					`RV_F3_ADD: res = (d.r.opcode == `RV_OP_OP && d.r.funct7 == `RV_F7_SUB) ?
						a - b : a + b;
					`RV_F3_SLL: res = a << b[5:0];
					`RV_F3_SLT: res = {63'b0, $signed(a) < $signed(b)};
					`RV_F3_XOR: res = a ^ b;
					`RV_F3_SRL: res = a >> b[5:0];
					`RV_F3_OR:  res = a | b;
					default:    res = a & b;
				endcase
			end else if (d.r.opcode == `RV_OP_LUI) begin
				wr  = 1'b1;
				res = {{32{d.u.imm[19]}}, d.u.imm, 12'b0};
			end else if (d.r.opcode == `RV_OP_LOAD || d.r.opcode == `RV_OP_STORE) begin
				if (d.r.opcode == `RV_OP_STORE) begin
					imm_i = {{52{d.s.imm_hi[6]}}, d.s.imm_hi, d.s.imm_lo};
				end
				rec = xfer_q.size() > 0 ? xfer_q.pop_front() : '1;
				res = xdata_q.size() > 0 ? xdata_q.pop_front() : '1;
				assert (rec[63:0] == a + imm_i && rec[64] == (d.r.opcode == `RV_OP_STORE))
				else begin
					$display("Mismatch at %0t: data access %h, expected %h", $time,
						rec[63:0], a + imm_i);
					mism_cnt++;
				end
				if (d.r.opcode == `RV_OP_STORE) begin
					assert (res == b) else begin
						$display("Mismatch at %0t: store data %h, expected %h", $time, res, b);
						mism_cnt++;
					end
					ref_mem[a + imm_i] = b;
				end else begin
					wr  = 1'b1;
					res = read_data(a + imm_i, 1'b1);
				end
			end else if (d.r.opcode == `RV_OP_BRANCH) begin
				if ((a == b) ^ (d.b.funct3 == `RV_F3_BNE)) begin
					nxt = pc + {{51{d.b.imm12}}, d.b.imm12, d.b.imm11,
						d.b.imm10_5, d.b.imm4_1, 1'b0};
				end
			end else if (d.r.opcode == `RV_OP_JAL) begin
				wr  = 1'b1;
				res = pc + 64'd4;
				nxt = pc + {{43{d.j.imm20}}, d.j.imm20, d.j.imm19_12, d.j.imm11,
					d.j.imm10_1, 1'b0};
				done = (nxt == pc);
			end
			if (wr && d.r.rd != 5'd0) begin
				assert (retire_o.rd_wena && retire_o.rd_addr == d.r.rd &&
					retire_o.rd_data == res) else begin
					$display("Mismatch at %0t: x%0d got %h, expected %h", $time, d.r.rd,
						retire_o.rd_data, res);
					mism_cnt++;
				end
				ref_regs[d.r.rd] = res;
			end else begin
				assert (!retire_o.rd_wena) else begin
					$display("Mismatch at %0t: rd write enable set on pc %h, expected clear",
						$time, pc);
					mism_cnt++;
				end
			end
			exp_pc = nxt;
		end
	end

	initial begin
		int total;
		void'($urandom(32'he910));
		rst_n_i          = 1'b0;
		if_ready_i       = 1'b0;
		if_data_read_i   = '0;
		mem_ready_i      = 1'b0;
		mem_data_read_i  = '0;
		cycles           = 0;
		mism_cnt         = 0;
		timeout_cnt      = 0;
		done             = 1'b0;
		exp_pc           = `RV_RESET_PC;
		for (int k = 0; k < 32; k++) begin
			ref_regs[k] = '0;
		end
		load_program();
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		while (!done && cycles < CYCLE_LIMIT) begin
			@(negedge clk);
		end
		if (!done) begin
			$display("Timeout: the final jal did not retire within %0d cycles", CYCLE_LIMIT);
			timeout_cnt++;
		end
		// every data transfer belongs to a retired load or store
		assert (xfer_q.size() == 0) else begin
			$display("Mismatch at %0t: %0d data transfers left, expected 0", $time,
				xfer_q.size());
			mism_cnt++;
		end
		total = mism_cnt + rvcpu_i.rvcpu_chk_i.err_cnt + timeout_cnt;
		$display("Summary: %0d mismatches, %0d assertion failures, %0d timeouts",
			mism_cnt, rvcpu_i.rvcpu_chk_i.err_cnt, timeout_cnt);
		if (total == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/rv_pipe_pkg.sv
rtl/fetch_unit.sv
rtl/id_stage.sv
rtl/regfile.sv
rtl/hazard_unit.sv
rtl/exe_stage.sv
rtl/me_stage.sv
rtl/rvcpu.sv
bench/rvcpu_chk.sv
bench/tb_rvcpu.sv
